//--- alu_ex.f
src/alu_pkg.sv
src/alu_adder.sv
src/alu_shifter.sv
src/alu_compare.sv
src/alu_ex.sv
bench/alu_ex_tb.sv

//--- bench/alu_ex_tb.sv
// directed testbench for the execute-stage ALU
// LFSR operands, lane reference model, per-group test tasks, final report

`timescale 1ns/1ps

module alu_ex_tb;

  import alu_pkg::*;

  localparam logic [31:0] SEED    = 32'h72e4_6664;
  localparam int          TIMEOUT = 20;
  localparam vec_mode_e   MODES [3] = '{VEC_MODE32, VEC_MODE16, VEC_MODE8};

  logic      clk;
  logic      rst_i;
  logic      valid_i;
  alu_req_t  req_i;
  logic      valid_o;
  alu_resp_t resp_o;

  logic [31:0] lfsr_q;
  int          mismatches;
  int          timeouts;

  alu_ex alu_ex_i (
    .clk     (clk),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .req_i   (req_i),
    .valid_o (valid_o),
    .resp_o  (resp_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // stimulus and reference
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr stepped once per bit taken
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    logic        fb;
    w = '0;
    for (int k = 0; k < 32; k++)
    begin
      // taps 32, 22, 2, 1
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      w      = {w[30:0], fb};
    end
    return w;
  endfunction

  // sign-extend a lane value of width lw
  function automatic longint sext(longint x, longint lw);
    if (((x >> (lw - 64'sd1)) & 64'sd1) != 64'sd0)
      return x - (64'sd1 <<< lw);
    return x;
  endfunction

  // lane rules per opcode over 32, 16 or 8 bit lanes
  function automatic alu_resp_t model(alu_op_e op, vec_mode_e mode,
                                      logic [31:0] a, logic [31:0] b);
    longint      lw;
    longint      mask;
    longint      la, lb, sa, sb, amt, r;
    logic        gt, eq, c, sgn;
    logic [31:0] res;
    alu_resp_t   resp;
    lw   = (mode == VEC_MODE8) ? 64'sd8 : (mode == VEC_MODE16) ? 64'sd16 : 64'sd32;
    mask = (64'sd1 <<< lw) - 64'sd1;
    sgn  = op inside {GTS, GES, LTS, LES, SLTS, SLETS, MIN, MAX};
    res  = '0;
    c    = 1'b0;
    for (longint i = 0; i < 64'sd32 / lw; i++)
    begin
      la  = (longint'(a) >> (i * lw)) & mask;
      lb  = (longint'(b) >> (i * lw)) & mask;
      sa  = sext(la, lw);
      sb  = sext(lb, lw);
      // low 5, 4 or 3 bits of the lane
      amt = lb & (lw - 64'sd1);
      eq  = (la == lb);
      gt  = sgn ? (sa > sb) : (la > lb);
      case (op)
        ADD, AVG, AVGU: r = la + lb;
        SUB:            r = la - lb;
        AND:            r = la & lb;
        OR:             r = la | lb;
        XOR:            r = la ^ lb;
        SLL:            r = la << amt;
        SRL:            r = la >> amt;
        SRA:            r = sa >>> amt;
        // rotate only wraps on the full word
        ROR:            r = (lw == 64'sd32) ? ((la >> amt) | (la << (lw - amt))) : (la >> amt);
        MIN, MINU:      r = gt ? lb : la;
        MAX, MAXU:      r = gt ? la : lb;
        default:        r = 64'sd0;
      endcase
      res = res | 32'((r & mask) << (i * lw));
      // last pass is the top lane so its relation wins
      case (op)
        EQ:                     c = eq;
        NE:                     c = !eq;
        GTS, GTU:               c = gt;
        GES, GEU:               c = gt | eq;
        LTS, LTU, SLTS, SLTU:   c = !(gt | eq);
        LES, LEU, SLETS, SLETU: c = !gt;
        default:                c = 1'b0;
      endcase
    end
    // averages shift the whole lane-sum word
    if (op == AVG)
      res = {res[31], res[31:1]};
    else if (op == AVGU)
      res = {1'b0, res[31:1]};
    else if (op inside {[EQ:SLETU]})
      res = {31'b0, c};
    resp.result = res;
    resp.cmp    = c;
    return resp;
  endfunction

  ////////////////////////////////////////////////////////////
  // drive and check
  ////////////////////////////////////////////////////////////

  task automatic drive_req(input logic v, input alu_op_e op, input vec_mode_e mode,
                           input logic [31:0] a, input logic [31:0] b);
    valid_i         = v;
    req_i.op        = op;
    req_i.vec_mode  = mode;
    req_i.operand_a = a;
    req_i.operand_b = b;
  endtask

  task automatic check_resp(input string name, input alu_resp_t exp);
    assert (resp_o === exp)
    else
    begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, resp_o);
    end
  endtask

  // one request and a wait for its strobe
  task automatic run_op(input alu_op_e op, input vec_mode_e mode,
                        input logic [31:0] a, input logic [31:0] b);
    string     name;
    alu_resp_t exp;
    int        cycles;
    name = $sformatf("%s/%s", op.name(), mode.name());
    exp  = model(op, mode, a, b);
    drive_req(1'b1, op, mode, a, b);
    @(posedge clk);
    #1;
    valid_i = 1'b0;
    cycles  = 0;
    while (valid_o !== 1'b1 && cycles < TIMEOUT)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (valid_o === 1'b1)
    else
    begin
      timeouts++;
      $display("Timeout: no valid response for %s", name);
    end
    if (valid_o === 1'b1)
      check_resp(name, exp);
  endtask

  // every opcode in a range in all modes with random operands
  task automatic sweep_ops(input alu_op_e first, input alu_op_e last, input int count);
    logic [31:0] a;
    logic [31:0] b;
    for (int k = int'(first); k <= int'(last); k++)
      for (int m = 0; m < 3; m++)
        for (int n = 0; n < count; n++)
        begin
          a = rand_word();
          b = rand_word();
          run_op(alu_op_e'(k[4:0]), MODES[m], a, b);
        end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic adder_tests();
    for (int m = 0; m < 3; m++)
    begin
      // carry and borrow at every lane edge
      run_op(ADD, MODES[m], 32'hffff_ffff, 32'h0000_0001);
      run_op(SUB, MODES[m], 32'h0000_0000, 32'h0101_0101);
      run_op(AVG, MODES[m], 32'h8000_0000, 32'h7fff_ffff);
    end
    sweep_ops(ADD, AVGU, 6);
  endtask

  task automatic shift_tests();
    for (int m = 0; m < 3; m++)
      run_op(SRA, MODES[m], 32'h8080_8080, 32'h0707_0707);
    sweep_ops(SLL, ROR, 8);
  endtask

  task automatic compare_tests();
    logic [31:0] x;
    for (int k = int'(EQ); k <= int'(SLETU); k++)
      for (int m = 0; m < 3; m++)
      begin
        x = rand_word();
        // equal operands, a sign flip per byte and a low bit flip
        run_op(alu_op_e'(k[4:0]), MODES[m], x, x);
        run_op(alu_op_e'(k[4:0]), MODES[m], x, x ^ 32'h8080_8080);
        run_op(alu_op_e'(k[4:0]), MODES[m], x, x ^ 32'h0000_0001);
      end
    sweep_ops(EQ, SLETU, 3);
  endtask

  // back-to-back burst followed by a gap
  task automatic timing_tests();
    alu_resp_t   exp;
    logic [31:0] a;
    logic [31:0] b;
    alu_op_e     op;
    for (int j = 0; j < 6; j++)
    begin
      a   = rand_word();
      b   = rand_word();
      op  = alu_op_e'(j[4:0] * 5'd4);
      exp = model(op, MODES[j % 3], a, b);
      drive_req(1'b1, op, MODES[j % 3], a, b);
      @(posedge clk);
      #1;
      assert (valid_o === 1'b1)
      else
      begin
        mismatches++;
        $display("Mismatch burst valid_o: expected 1, actual %b", valid_o);
      end
      check_resp("burst", exp);
    end
    valid_i = 1'b0;
    @(posedge clk);
    #1;
    assert (valid_o === 1'b0)
    else
    begin
      mismatches++;
      $display("Mismatch gap valid_o: expected 0, actual %b", valid_o);
    end
    // response holds through the gap
    check_resp("gap hold", exp);
  endtask

  initial
  begin
    mismatches = 0;
    timeouts   = 0;
    lfsr_q     = SEED;
    rst_i      = 1'b1;
    // a live request during reset must not reach the outputs
    drive_req(1'b1, ADD, VEC_MODE32, 32'h1234_5678, 32'h0000_0001);
    repeat (10) @(posedge clk);
    #1;
    rst_i   = 1'b0;
    valid_i = 1'b0;
    assert (valid_o === 1'b0 && resp_o === '0)
    else
    begin
      mismatches++;
      $display("Mismatch reset: expected 0 and 0, actual %b and %h", valid_o, resp_o);
    end

    adder_tests();
    sweep_ops(AND, XOR, 6);
    shift_tests();
    compare_tests();
    sweep_ops(MIN, MAXU, 8);
    timing_tests();

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module alu_ex_tb -f alu_ex.f -o alu_ex_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/alu_ex_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi

exit 0

//--- src/alu_adder.sv
// lane-partitioned adder for add, subtract and averaging
// carry-break bits sit below each byte of the operands

`timescale 1ns/1ps

module alu_adder (
  input  alu_pkg::alu_req_t        req_i,
  output logic [alu_pkg::XLEN-1:0] sum_o,
  output logic [alu_pkg::XLEN-1:0] avg_o
);

  import alu_pkg::*;

  logic                 is_sub;
  logic [XLEN-1:0]      op_b;
  logic [NUM_LANES-1:0] lane_start;
  logic [ADDER_W-1:0]   in_a;
  logic [ADDER_W-1:0]   in_b;
  logic [ADDER_W-1:0]   sum_ext;

  assign is_sub = (req_i.op == SUB);

  // subtract as a + ~b, the +1 comes in through the break bits
  assign op_b = is_sub ? ~req_i.operand_b : req_i.operand_b;

  // bytes that begin a lane in the current mode, byte 0 always does
  always_comb
  begin
    case (req_i.vec_mode)
      VEC_MODE16: lane_start = 4'b0101;
      VEC_MODE8:  lane_start = 4'b1111;
      default:    lane_start = 4'b0001;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // operand spreading
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (lane_start[i])
      begin
        // 0+0 drops the lower carry, 1+1 injects a fresh +1 for sub
        in_a[i*(LANE_W+1)] = is_sub;
        in_b[i*(LANE_W+1)] = is_sub;
      end
      else
      begin
        // 1+0 lets the carry ripple on into this byte
        in_a[i*(LANE_W+1)] = 1'b1;
        in_b[i*(LANE_W+1)] = 1'b0;
      end
      in_a[i*(LANE_W+1)+1 +: LANE_W] = req_i.operand_a[i*LANE_W +: LANE_W];
      in_b[i*(LANE_W+1)+1 +: LANE_W] = op_b[i*LANE_W +: LANE_W];
    end
  end

  // the single wide adder
  assign sum_ext = in_a + in_b;

  // drop the break bits again
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      sum_o[i*LANE_W +: LANE_W] = sum_ext[i*(LANE_W+1)+1 +: LANE_W];
    end
  end

  // averaging works on the whole word, top bit zero for the unsigned form
  assign avg_o = {(req_i.op == AVGU) ? 1'b0 : sum_o[XLEN-1], sum_o[XLEN-1:1]};

  // decode above has no meaning for the unused mode encoding
  always_comb
  begin
    assert (req_i.vec_mode !== 2'b01)
      else $error("alu_adder: reserved vector mode on request");
  end

endmodule

//--- src/alu_compare.sv
// lane comparator with per-byte equal and greater flags
// comparison result of the top lane and the min/max lane mux

`timescale 1ns/1ps

module alu_compare (
  input  alu_pkg::alu_req_t        req_i,
  output logic                     cmp_o,
  output logic [alu_pkg::XLEN-1:0] minmax_o
);

  import alu_pkg::*;

  logic [XLEN-1:0]      op_a;
  logic [XLEN-1:0]      op_b;
  logic                 is_signed_op;
  logic                 do_min;
  logic [NUM_LANES-1:0] cmp_signed;
  logic [NUM_LANES-1:0] eq_byte;
  logic [NUM_LANES-1:0] gt_byte;
  logic [NUM_LANES-1:0] is_equal;
  logic [NUM_LANES-1:0] is_greater;
  logic [NUM_LANES-1:0] cmp_result;
  logic [NUM_LANES-1:0] sel_a;

  assign op_a = req_i.operand_a;
  assign op_b = req_i.operand_b;

  always_comb
  begin
    case (req_i.op)
      GTS, GES, LTS, LES, SLTS, SLETS, MIN, MAX: is_signed_op = 1'b1;
      default:                                   is_signed_op = 1'b0;
    endcase
  end

  // sign only matters in the top byte of each active lane
  always_comb
  begin
    case (req_i.vec_mode)
      VEC_MODE16: cmp_signed = {2{is_signed_op, 1'b0}};
      VEC_MODE8:  cmp_signed = {NUM_LANES{is_signed_op}};
      default:    cmp_signed = {is_signed_op, 3'b000};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // byte flags and lane merge
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      eq_byte[i] = (op_a[i*LANE_W +: LANE_W] == op_b[i*LANE_W +: LANE_W]);
      // 9-bit compare, extension bit is the sign or zero
      gt_byte[i] = $signed({op_a[i*LANE_W+LANE_W-1] & cmp_signed[i], op_a[i*LANE_W +: LANE_W]})
                 > $signed({op_b[i*LANE_W+LANE_W-1] & cmp_signed[i], op_b[i*LANE_W +: LANE_W]});
    end
  end

  // upper byte decides, lower byte only breaks a tie
  always_comb
  begin
    case (req_i.vec_mode)
      VEC_MODE16:
      begin
        is_equal[1:0]   = {2{eq_byte[1] & eq_byte[0]}};
        is_equal[3:2]   = {2{eq_byte[3] & eq_byte[2]}};
        is_greater[1:0] = {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}};
        is_greater[3:2] = {2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}};
      end

      VEC_MODE8:
      begin
        is_equal   = eq_byte;
        is_greater = gt_byte;
      end

      default:
      begin
        is_equal   = {NUM_LANES{&eq_byte}};
        is_greater = {NUM_LANES{gt_byte[3] | (eq_byte[3] & (gt_byte[2]
                               | (eq_byte[2] & (gt_byte[1]
                               | (eq_byte[1] & gt_byte[0])))))}};
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // result and min/max
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (req_i.op)
      EQ:                     cmp_result = is_equal;
      NE:                     cmp_result = ~is_equal;
      GTS, GTU:               cmp_result = is_greater;
      GES, GEU:               cmp_result = is_greater | is_equal;
      LTS, LTU, SLTS, SLTU:   cmp_result = ~(is_greater | is_equal);
      LES, LEU, SLETS, SLETU: cmp_result = ~is_greater;
      default:                cmp_result = is_equal;
    endcase
  end

  // top lane stands for the whole comparison
  assign cmp_o = cmp_result[NUM_LANES-1];

  // max keeps a where a > b, min flips the choice
  assign do_min = (req_i.op == MIN) || (req_i.op == MINU);
  assign sel_a  = is_greater ^ {NUM_LANES{do_min}};

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      minmax_o[i*LANE_W +: LANE_W] = sel_a[i] ? op_a[i*LANE_W +: LANE_W]
                                              : op_b[i*LANE_W +: LANE_W];
    end
  end

endmodule

//--- src/alu_ex.sv
// execute-stage ALU top with adder, shifter and comparator
// result select by opcode, one output register and valid strobe

`timescale 1ns/1ps

module alu_ex (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               valid_i,
  input  alu_pkg::alu_req_t  req_i,
  output logic               valid_o,
  output alu_pkg::alu_resp_t resp_o
);

  import alu_pkg::*;

  logic [XLEN-1:0] sum_res;
  logic [XLEN-1:0] avg_res;
  logic [XLEN-1:0] shift_res;
  logic [XLEN-1:0] minmax_res;
  logic            cmp_res;
  alu_resp_t       resp_d;

  ////////////////////////////////////////////////////////////
  // datapath blocks, all combinational
  ////////////////////////////////////////////////////////////

  alu_adder adder_i (
    .req_i (req_i),
    .sum_o (sum_res),
    .avg_o (avg_res)
  );

  alu_shifter shifter_i (
    .req_i   (req_i),
    .shift_o (shift_res)
  );

  alu_compare compare_i (
    .req_i    (req_i),
    .cmp_o    (cmp_res),
    .minmax_o (minmax_res)
  );

  ////////////////////////////////////////////////////////////
  // result select
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    // cmp stays zero outside the comparison group
    resp_d = '0;

    case (req_i.op)
      ADD, SUB:           resp_d.result = sum_res;
      AVG, AVGU:          resp_d.result = avg_res;
      AND:                resp_d.result = req_i.operand_a & req_i.operand_b;
      OR:                 resp_d.result = req_i.operand_a | req_i.operand_b;
      XOR:                resp_d.result = req_i.operand_a ^ req_i.operand_b;
      SLL, SRL, SRA, ROR: resp_d.result = shift_res;
      MIN, MINU, MAX, MAXU: resp_d.result = minmax_res;

      EQ, NE, GTS, GTU, GES, GEU, LTS, LTU, LES, LEU,
      SLTS, SLTU, SLETS, SLETU:
      begin
        // flag zero-extended into the result word
        resp_d.result = {{(XLEN-1){1'b0}}, cmp_res};
        resp_d.cmp    = cmp_res;
      end

      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // output stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      valid_o <= 1'b0;
      resp_o  <= '0;
    end
    else
    begin
      valid_o <= valid_i;
      // response holds between strobes
      if (valid_i)
        resp_o <= resp_d;
    end
  end

  // strobe is low in the first cycle after a reset edge
  assert property (@(posedge clk) rst_i |=> !valid_o)
    else $error("alu_ex: valid_o set right after reset");

  // one-cycle latency, every request gets its response on the next cycle
  assert property (@(posedge clk) !rst_i |=> (valid_o == $past(valid_i)))
    else $error("alu_ex: valid_o does not follow valid_i by one cycle");

endmodule

//--- src/alu_pkg.sv
// ALU package with operand and lane widths
// opcode and vector-mode enums, request and response structs

package alu_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // full operand width
  localparam int XLEN      = 32;
  // smallest simd lane, one byte
  localparam int LANE_W    = 8;
  localparam int NUM_LANES = XLEN / LANE_W;
  // adder gets one carry-break bit below every byte
  localparam int ADDER_W   = XLEN + NUM_LANES;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // lane partitioning, 2'b01 is left unused
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  typedef enum logic [4:0] {
    // adder group
    ADD   = 5'd0,
    SUB   = 5'd1,
    AVG   = 5'd2,
    AVGU  = 5'd3,
    // bitwise
    AND   = 5'd4,
    OR    = 5'd5,
    XOR   = 5'd6,
    // shifter
    SLL   = 5'd7,
    SRL   = 5'd8,
    SRA   = 5'd9,
    ROR   = 5'd10,
    // comparisons, result is 0 or 1
    EQ    = 5'd11,
    NE    = 5'd12,
    GTS   = 5'd13,
    GTU   = 5'd14,
    GES   = 5'd15,
    GEU   = 5'd16,
    LTS   = 5'd17,
    LTU   = 5'd18,
    LES   = 5'd19,
    LEU   = 5'd20,
    SLTS  = 5'd21,
    SLTU  = 5'd22,
    SLETS = 5'd23,
    SLETU = 5'd24,
    // lane-wise min and max
    MIN   = 5'd25,
    MINU  = 5'd26,
    MAX   = 5'd27,
    MAXU  = 5'd28
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // request and response
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e         op;
    vec_mode_e       vec_mode;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } alu_req_t;

  // cmp only carries meaning for comparison opcodes
  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            cmp;
  } alu_resp_t;

endpackage

//--- src/alu_shifter.sv
// lane-aware shifter for sll, srl, sra and ror
// left shifts reuse the right shifter on bit-reversed data

`timescale 1ns/1ps

module alu_shifter (
  input  alu_pkg::alu_req_t        req_i,
  output logic [alu_pkg::XLEN-1:0] shift_o
);

  import alu_pkg::*;

  logic              shift_left;
  logic              is_sra;
  logic [XLEN-1:0]   op_a_rev;
  logic [XLEN-1:0]   amt_rev;
  logic [XLEN-1:0]   shift_op_a;
  logic [XLEN-1:0]   shift_amt;
  logic [2*XLEN-1:0] ror_wide;
  logic [XLEN-1:0]   right_res;
  logic [XLEN-1:0]   left_res;

  assign shift_left = (req_i.op == SLL);
  assign is_sra     = (req_i.op == SRA);

  // mirrored operand a
  always_comb
  begin
    for (int k = 0; k < XLEN; k++)
    begin
      op_a_rev[k] = req_i.operand_a[XLEN-1-k];
    end
  end

  // mirroring the data also mirrors the lane order, so the amounts follow
  always_comb
  begin
    case (req_i.vec_mode)
      VEC_MODE16: amt_rev = {req_i.operand_b[15:0], req_i.operand_b[31:16]};
      VEC_MODE8:  amt_rev = {req_i.operand_b[7:0], req_i.operand_b[15:8],
                             req_i.operand_b[23:16], req_i.operand_b[31:24]};
      default:    amt_rev = req_i.operand_b;
    endcase
  end

  assign shift_op_a = shift_left ? op_a_rev : req_i.operand_a;
  assign shift_amt  = shift_left ? amt_rev : req_i.operand_b;

  // doubled word, the low half is the rotated value
  assign ror_wide = {shift_op_a, shift_op_a} >> shift_amt[4:0];

  ////////////////////////////////////////////////////////////
  // right shifter
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    // plain 32-bit logical shift unless a case below overrides it
    right_res = shift_op_a >> shift_amt[4:0];

    case (req_i.vec_mode)
      VEC_MODE16:
      begin
        // 4 amount bits per half, ror falls back to logical
        if (is_sra)
        begin
          right_res[31:16] = $unsigned($signed(shift_op_a[31:16]) >>> shift_amt[19:16]);
          right_res[15:0]  = $unsigned($signed(shift_op_a[15:0]) >>> shift_amt[3:0]);
        end
        else
        begin
          right_res[31:16] = shift_op_a[31:16] >> shift_amt[19:16];
          right_res[15:0]  = shift_op_a[15:0] >> shift_amt[3:0];
        end
      end

      VEC_MODE8:
      begin
        // 3 amount bits per byte lane
        for (int i = 0; i < NUM_LANES; i++)
        begin
          if (is_sra)
            right_res[i*LANE_W +: LANE_W] =
              $unsigned($signed(shift_op_a[i*LANE_W +: LANE_W]) >>> shift_amt[i*LANE_W +: 3]);
          else
            right_res[i*LANE_W +: LANE_W] =
              shift_op_a[i*LANE_W +: LANE_W] >> shift_amt[i*LANE_W +: 3];
        end
      end

      default:
      begin
        if (is_sra)
          right_res = $unsigned($signed(shift_op_a) >>> shift_amt[4:0]);
        else if (req_i.op == ROR)
          right_res = ror_wide[XLEN-1:0];
      end
    endcase
  end

  // mirror back for sll
  always_comb
  begin
    for (int k = 0; k < XLEN; k++)
    begin
      left_res[k] = right_res[XLEN-1-k];
    end
  end

  assign shift_o = shift_left ? left_res : right_res;

endmodule
